/* run.sh */
#!/usr/bin/env bash
# Build the adder testbench with Verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module fp_adder_tb -o fp_adder_sim
if [ $? -ne 0 ]; then
	echo "Verilator build did not succeed"
	exit 1
fi

./obj_dir/fp_adder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src/fp_add_align.sv */
//####################################################################
// Stage 2 of the adder. Shifted-out bits are dropped, so the
// smaller operand is truncated before the add
//####################################################################
`timescale 1ns/10ps

module fp_add_align import fp_add_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      advance,
	input  unpacked_t prev,
	output aligned_t  stage
);

	logic [SIG_WIDTH-1:0] big_ext;
	logic [SIG_WIDTH-1:0] small_ext;
	logic [SIG_WIDTH-1:0] small_shifted;
	aligned_t stage_nxt;

	// Room above the hidden bit for a carry and the sign
	assign big_ext = {2'b00, prev.big_significand};
	assign small_ext = {2'b00, prev.small_significand};

	// Large differences push everything out
	always_comb
	begin
		if (prev.exp_diff >= SIG_WIDTH)
			small_shifted = '0;
		else
			small_shifted = small_ext >> prev.exp_diff;
	end

	always_comb
	begin
		// Negative operands go to two's complement
		if (prev.big_sign)
			stage_nxt.significand1 = ~big_ext + 1'b1;
		else
			stage_nxt.significand1 = big_ext;

		if (prev.small_sign)
			stage_nxt.significand2 = ~small_shifted + 1'b1;
		else
			stage_nxt.significand2 = small_shifted;

		// Result starts at the big exponent
		stage_nxt.exponent = prev.big_exponent;
		stage_nxt.kind = prev.kind;
		stage_nxt.inf_sign = prev.inf_sign;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			stage <= '0;
		else if (advance)
			stage <= stage_nxt;
	end

	// Stage 1 must hand over a normalized or flushed big operand
	big_hidden_bit: assert property (@(posedge clk) disable iff (reset)
		advance |-> prev.big_significand[FRAC_WIDTH] || (prev.big_significand == '0))
		else $error("big significand lacks its hidden bit");

endmodule

/* src/fp_add_normalize.sv */
//####################################################################
// Stage 4 of the adder. Truncates, gives plus zero for an exact
// cancellation and never produces a subnormal result
//####################################################################
`timescale 1ns/10ps

module fp_add_normalize import fp_add_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    advance,
	input  summed_t prev,
	output float_t  result
);

	logic carry;
	logic [LZ_WIDTH-1:0] lz;
	logic [FRAC_WIDTH:0] shifted;
	float_t finite;
	float_t result_nxt;

	// Sum spilled into the overflow bit
	assign carry = prev.magnitude[FRAC_WIDTH+1];

	// Leading zeros from the hidden bit down, highest set bit wins
	always_comb
	begin
		lz = LZ_WIDTH'(FRAC_WIDTH + 1);
		for (int i = 0; i <= FRAC_WIDTH; i++)
		begin
			if (prev.magnitude[i])
				lz = LZ_WIDTH'(FRAC_WIDTH - i);
		end
	end

	assign shifted = prev.magnitude[FRAC_WIDTH:0] << lz;

	always_comb
	begin
		finite.sign = prev.sign;
		finite.exponent = '0;
		finite.fraction = '0;
		if (carry)
		begin
			// Shift right one, low bit is truncated
			if (prev.exponent >= EXP_MAX - 1'b1)
				finite.exponent = EXP_MAX;
			else
			begin
				finite.exponent = prev.exponent + 1'b1;
				finite.fraction = prev.magnitude[FRAC_WIDTH:1];
			end
		end
		else if ((prev.magnitude == '0) || (lz >= prev.exponent))
			// Exact zero or underflow, both flush to plus zero
			finite.sign = 1'b0;
		else
		begin
			finite.exponent = prev.exponent - lz;
			finite.fraction = shifted[FRAC_WIDTH-1:0];
		end
	end

	// Special classes override the computed sum
	always_comb
	begin
		case (prev.kind)
			NAN: result_nxt = '{sign: 1'b0, exponent: EXP_MAX, fraction: NAN_FRACTION};
			INF: result_nxt = '{sign: prev.inf_sign, exponent: EXP_MAX, fraction: '0};
			default: result_nxt = finite;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result <= '0;
		else if (advance)
			result <= result_nxt;
	end

	// A finite input must never leave as a NaN pattern
	finite_not_nan: assert property (@(posedge clk) disable iff (reset)
		advance && (prev.kind == FINITE)
		|=> (result.exponent != EXP_MAX) || (result.fraction == '0))
		else $error("finite sum packed with a NaN encoding");

endmodule

/* src/fp_add_pipe_ctrl.sv */
//####################################################################
// Valid tracking for the adder pipeline
// Whole pipeline stalls on back-pressure, bubbles are kept
//####################################################################
`timescale 1ns/10ps

module fp_add_pipe_ctrl import fp_add_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic out_ready,
	output logic in_ready,
	output logic out_valid,
	output logic advance
);

	// One valid bit per register stage, bit 0 is stage 1
	logic [STAGE_COUNT-1:0] valid;

	// Last stage holds the result seen on the output
	assign out_valid = valid[STAGE_COUNT-1];

	// Freeze everything while a result waits to be taken
	assign advance = !(out_valid && !out_ready);

	// New operands only enter when the pipeline moves
	assign in_ready = advance;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			valid <= '0;
		else if (advance)
			valid <= {valid[STAGE_COUNT-2:0], in_valid};
	end

	// A held result may not disappear before it is taken
	hold_result: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid)
		else $error("out_valid dropped while out_ready was low");

endmodule

/* src/fp_add_pkg.sv */
//####################################################################
// Shared formats for the binary32 adder pipeline
// Stage widths are fixed, so no module takes parameters
//####################################################################
package fp_add_pkg;

	// IEEE-754 binary32 field widths
	localparam int EXP_WIDTH = 8;
	localparam int FRAC_WIDTH = 23;

	// Sign, overflow bit and hidden bit on top of the fraction
	localparam int SIG_WIDTH = FRAC_WIDTH + 3;

	// Width of a leading-zero count over hidden bit plus fraction
	localparam int LZ_WIDTH = $clog2(FRAC_WIDTH + 2);

	// Register stages between input and output
	localparam int STAGE_COUNT = 4;

	localparam logic [EXP_WIDTH-1:0] EXP_MAX = {EXP_WIDTH{1'b1}};

	// Canonical quiet NaN has only the top fraction bit set
	localparam logic [FRAC_WIDTH-1:0] NAN_FRACTION = {1'b1, {(FRAC_WIDTH - 1){1'b0}}};

	// Special-case class that rides along with each item
	typedef enum logic [1:0]
	{
		FINITE,
		INF,
		NAN
	} result_kind_e;

	typedef struct packed
	{
		logic sign;
		logic [EXP_WIDTH-1:0] exponent;
		logic [FRAC_WIDTH-1:0] fraction;
	} float_t;

	// Stage 1 output, operands ordered by magnitude
	typedef struct packed
	{
		logic big_sign;
		logic [EXP_WIDTH-1:0] big_exponent;
		logic [FRAC_WIDTH:0] big_significand;
		logic small_sign;
		logic [FRAC_WIDTH:0] small_significand;
		logic [EXP_WIDTH-1:0] exp_diff;
		result_kind_e kind;
		logic inf_sign;
	} unpacked_t;

	// Stage 2 output, both significands in two's complement
	typedef struct packed
	{
		logic [SIG_WIDTH-1:0] significand1;
		logic [SIG_WIDTH-1:0] significand2;
		logic [EXP_WIDTH-1:0] exponent;
		result_kind_e kind;
		logic inf_sign;
	} aligned_t;

	// Stage 3 output, sum back in sign and magnitude form
	typedef struct packed
	{
		logic sign;
		logic [SIG_WIDTH-1:0] magnitude;
		logic [EXP_WIDTH-1:0] exponent;
		result_kind_e kind;
		logic inf_sign;
	} summed_t;

endpackage

/* src/fp_add_sum.sv */
//####################################################################
// Stage 3 of the adder. Sum of two aligned significands always
// fits below the sign bit, so no carry is lost here
//####################################################################
`timescale 1ns/10ps

module fp_add_sum import fp_add_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     advance,
	input  aligned_t prev,
	output summed_t  stage
);

	logic [SIG_WIDTH-1:0] sum;
	summed_t stage_nxt;

	// Two's complement add, wraps into the sign bit when negative
	assign sum = prev.significand1 + prev.significand2;

	always_comb
	begin
		// Back to sign and magnitude
		if (sum[SIG_WIDTH-1])
		begin
			stage_nxt.magnitude = ~sum + 1'b1;
			stage_nxt.sign = 1'b1;
		end
		else
		begin
			stage_nxt.magnitude = sum;
			stage_nxt.sign = 1'b0;
		end

		stage_nxt.exponent = prev.exponent;
		stage_nxt.kind = prev.kind;
		stage_nxt.inf_sign = prev.inf_sign;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			stage <= '0;
		else if (advance)
			stage <= stage_nxt;
	end

endmodule

/* src/fp_add_unpack.sv */
//####################################################################
// Stage 1 of the adder. Subnormal inputs are flushed to zero
// Zero keeps its sign here, the sum stage decides the final sign
//####################################################################
`timescale 1ns/10ps

module fp_add_unpack import fp_add_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      advance,
	input  float_t    a,
	input  float_t    b,
	output unpacked_t stage
);

	logic a_nan;
	logic b_nan;
	logic a_inf;
	logic b_inf;
	logic a_is_big;
	float_t big_op;
	float_t small_op;
	logic [FRAC_WIDTH:0] big_sig;
	logic [FRAC_WIDTH:0] small_sig;
	unpacked_t stage_nxt;

	// Special operand classes
	assign a_nan = (a.exponent == EXP_MAX) && (a.fraction != '0);
	assign b_nan = (b.exponent == EXP_MAX) && (b.fraction != '0);
	assign a_inf = (a.exponent == EXP_MAX) && (a.fraction == '0);
	assign b_inf = (b.exponent == EXP_MAX) && (b.fraction == '0);

	// Larger exponent wins, fraction breaks a tie
	assign a_is_big = (a.exponent > b.exponent)
		|| ((a.exponent == b.exponent) && (a.fraction >= b.fraction));

	assign big_op = a_is_big ? a : b;
	assign small_op = a_is_big ? b : a;

	// Zero exponent means zero or subnormal, both become zero
	assign big_sig = (big_op.exponent == '0) ? '0 : {1'b1, big_op.fraction};
	assign small_sig = (small_op.exponent == '0) ? '0 : {1'b1, small_op.fraction};

	always_comb
	begin
		stage_nxt.big_sign = big_op.sign;
		stage_nxt.big_exponent = big_op.exponent;
		stage_nxt.big_significand = big_sig;
		stage_nxt.small_sign = small_op.sign;
		stage_nxt.small_significand = small_sig;

		// Never negative since the big operand has the larger exponent
		stage_nxt.exp_diff = big_op.exponent - small_op.exponent;

		// Opposite infinities have no meaningful sum
		if (a_nan || b_nan || (a_inf && b_inf && (a.sign != b.sign)))
			stage_nxt.kind = NAN;
		else if (a_inf || b_inf)
			stage_nxt.kind = INF;
		else
			stage_nxt.kind = FINITE;

		// Both infinite means same sign here, so either one works
		stage_nxt.inf_sign = a_inf ? a.sign : b.sign;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			stage <= '0;
		else if (advance)
			stage <= stage_nxt;
	end

endmodule

/* src/fp_adder.sv */
//####################################################################
// Four-stage binary32 adder with valid/ready on both sides
// Result appears four accepted cycles after its operands
//####################################################################
`timescale 1ns/10ps

module fp_adder import fp_add_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   in_valid,
	input  float_t in_a,
	input  float_t in_b,
	output logic   in_ready,
	output logic   out_valid,
	input  logic   out_ready,
	output float_t out_result
);

	// Common enable for every stage register
	logic advance;

	// Stage registers between the blocks
	unpacked_t unpacked;
	aligned_t aligned;
	summed_t summed;

	fp_add_pipe_ctrl u_ctrl
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.advance(advance)
	);

	// Classify, flush and order
	fp_add_unpack u_unpack
	(
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.a(in_a),
		.b(in_b),
		.stage(unpacked)
	);

	// Line up the small operand
	fp_add_align u_align
	(
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.prev(unpacked),
		.stage(aligned)
	);

	fp_add_sum u_sum
	(
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.prev(aligned),
		.stage(summed)
	);

	// Renormalize and pack into binary32
	fp_add_normalize u_normalize
	(
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.prev(summed),
		.result(out_result)
	);

endmodule

/* verif/fp_adder_tb.sv */
//####################################################################
// Concurrent assertions check every result against a queue of sums
// Integer sums stay below 2^21, so their expected floats are exact
//####################################################################
`timescale 1ns/10ps

module fp_adder_tb import fp_add_pkg::*;
();

	localparam int INT_PAIRS = 200;
	localparam int ZERO_ROUNDS = 10;
	localparam int SPECIAL_ROUNDS = 4;
	localparam int BP_PAIRS = 100;
	localparam int LAT_PAIRS = 8;
	// Three pairs per zero round plus one, six per special round, two overflows
	localparam int TOTAL_OPS = INT_PAIRS + 3 * ZERO_ROUNDS + 1
		+ 6 * SPECIAL_ROUNDS + 2 + BP_PAIRS + LAT_PAIRS;
	localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 100;

	// IEEE-754 encodings used as expected values
	localparam float_t POS_ZERO = 32'h0000_0000;
	localparam float_t NEG_ZERO = 32'h8000_0000;
	localparam float_t POS_INF = 32'h7f80_0000;
	localparam float_t NEG_INF = 32'hff80_0000;
	localparam float_t QNAN = 32'h7fc0_0000;
	localparam float_t MAX_FINITE = 32'h7f7f_ffff;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	float_t in_a;
	float_t in_b;
	float_t out_result;

	// Scoreboard state, only changed at the falling edge
	float_t exp_q[$];
	float_t drive_exp;
	float_t front;
	float_t seen_result;
	int pending = 0;
	logic take_pending = 1'b0;

	logic [31:0] lfsr_state = 32'h6677_3b93;
	logic random_ready;
	logic lat_check;
	int cycle_count = 0;
	string test_name;

	fp_adder u_dut
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_a(in_a),
		.in_b(in_b),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "stopping at the first error");
	endtask

	// Galois LFSR, one step per bit taken
	function logic lfsr_bit();
		logic bit_out;
		bit_out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (bit_out)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return bit_out;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
			bits = {bits[30:0], lfsr_bit()};
		return bits;
	endfunction

	// Magnitude below 2^20 with a random sign
	function automatic int random_int();
		int magnitude;
		magnitude = int'(random_bits(20));
		return lfsr_bit() ? -magnitude : magnitude;
	endfunction

	// Normal numbers only, exponent kept off 0 and 255
	function automatic float_t random_normal();
		float_t f;
		f.sign = lfsr_bit();
		f.exponent = 8'(random_bits(8));
		if (f.exponent == 8'd0)
			f.exponent = 8'd1;
		if (f.exponent == 8'd255)
			f.exponent = 8'd254;
		f.fraction = 23'(random_bits(23));
		return f;
	endfunction

	// Zero exponent with a nonzero fraction
	function automatic float_t random_subnormal();
		float_t f;
		f.sign = lfsr_bit();
		f.exponent = 8'd0;
		f.fraction = 23'(random_bits(23)) | 23'd1;
		return f;
	endfunction

	function automatic float_t random_nan();
		float_t f;
		f.sign = lfsr_bit();
		f.exponent = 8'd255;
		f.fraction = 23'(random_bits(23)) | 23'd1;
		return f;
	endfunction

	function automatic float_t negate(input float_t f);
		return {~f.sign, f.exponent, f.fraction};
	endfunction

	// Exact conversion, valid for magnitudes below 2^24
	function automatic float_t int_to_float(input int value);
		float_t f;
		logic [31:0] mag;
		int msb;
		f = POS_ZERO;
		if (value != 0)
		begin
			mag = (value < 0) ? -value : value;
			msb = 0;
			for (int i = 0; i < 32; i++)
				if (mag[i])
					msb = i;
			f.sign = (value < 0);
			f.exponent = 8'(127 + msb);
			f.fraction = 23'(mag << (23 - msb));
		end
		return f;
	endfunction

	// Step to just after the next rising edge, out_ready follows the mode
	task automatic next_cycle();
		@(posedge clk);
		#1;
		if (random_ready)
			out_ready = lfsr_bit();
		else
			out_ready = 1'b1;
	endtask

	// Hold the pair until an edge where in_ready is high
	task automatic send_pair(input float_t a, input float_t b, input float_t sum);
		in_valid = 1'b1;
		in_a = a;
		in_b = b;
		drive_exp = sum;
		@(negedge clk);
		while (!in_ready)
		begin
			next_cycle();
			@(negedge clk);
		end
		next_cycle();
		in_valid = 1'b0;
	endtask

	task automatic send_int_pair();
		int x;
		int y;
		x = random_int();
		y = random_int();
		send_pair(int_to_float(x), int_to_float(y), int_to_float(x + y));
	endtask

	task automatic wait_drain();
		in_valid = 1'b0;
		while (exp_q.size() != 0)
			next_cycle();
	endtask

	// Mid-cycle update, all handshake signals are stable here
	always @(negedge clk)
	begin
		if (!reset)
		begin
			// Result taken at the edge just past
			if (take_pending)
				void'(exp_q.pop_front());
			// Pair accepted at the coming edge
			if (in_valid && in_ready)
				exp_q.push_back(drive_exp);
			take_pending = out_valid && out_ready;
			seen_result = out_result;
			pending = exp_q.size();
			front = (pending != 0) ? exp_q[0] : POS_ZERO;
		end
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
			fail_run($sformatf("simulation timed out after %0d cycles", cycle_count));
	end

	// Every taken result needs an accepted pair behind it
	result_expected: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready |-> (pending != 0))
		else fail_run("a result was taken with no pair outstanding");

	result_matches: assert property (@(posedge clk) disable iff (reset)
		out_valid && out_ready && (pending != 0) |-> (out_result == front))
		else fail_run($sformatf("ERROR %s: expected %h, actual %h",
			test_name, front, seen_result));

	ready_rule: assert property (@(posedge clk)
		in_ready == !(out_valid && !out_ready))
		else fail_run("in_ready is wrong for the current out_valid and out_ready");

	reset_idle: assert property (@(posedge clk)
		reset |-> !out_valid && in_ready)
		else fail_run("pipeline is not idle while reset is held");

	// Lone pair, out_valid rises four edges after acceptance
	latency_four: assert property (@(posedge clk) disable iff (reset)
		lat_check && in_valid && in_ready |-> ##3 !out_valid ##1 out_valid)
		else fail_run("result missed the four-cycle pipeline latency");

	initial
	begin
		float_t x;
		float_t inf;
		float_t nan;
		reset = 1'b1;
		in_valid = 1'b0;
		in_a = POS_ZERO;
		in_b = POS_ZERO;
		out_ready = 1'b1;
		drive_exp = POS_ZERO;
		random_ready = 1'b0;
		lat_check = 1'b0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		test_name = "integer sums";
		repeat (INT_PAIRS) send_int_pair();
		wait_drain();

		test_name = "cancellation and zero";
		repeat (ZERO_ROUNDS)
		begin
			x = random_normal();
			send_pair(x, negate(x), POS_ZERO);
			send_pair(lfsr_bit() ? NEG_ZERO : POS_ZERO, x, x);
			send_pair(random_subnormal(), x, x);
		end
		// Zero magnitude always packs as plus zero
		send_pair(NEG_ZERO, NEG_ZERO, POS_ZERO);
		wait_drain();

		test_name = "specials";
		repeat (SPECIAL_ROUNDS)
		begin
			x = random_normal();
			inf = lfsr_bit() ? NEG_INF : POS_INF;
			nan = random_nan();
			send_pair(inf, x, inf);
			send_pair(x, negate(inf), negate(inf));
			send_pair(inf, inf, inf);
			send_pair(inf, negate(inf), QNAN);
			send_pair(nan, x, QNAN);
			send_pair(x, nan, QNAN);
		end
		wait_drain();

		test_name = "overflow";
		send_pair(MAX_FINITE, MAX_FINITE, POS_INF);
		send_pair(negate(MAX_FINITE), negate(MAX_FINITE), NEG_INF);
		wait_drain();

		test_name = "back-pressure";
		random_ready = 1'b1;
		repeat (BP_PAIRS) send_int_pair();
		wait_drain();
		random_ready = 1'b0;
		next_cycle();

		// Each pair goes alone through an empty pipeline
		test_name = "latency";
		lat_check = 1'b1;
		repeat (LAT_PAIRS)
		begin
			send_int_pair();
			wait_drain();
		end
		lat_check = 1'b0;

		if (exp_q.size() == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
			fail_run("results still outstanding at the end of the run");
	end

endmodule

/* vlog.f */
src/fp_add_pkg.sv
src/fp_add_pipe_ctrl.sv
src/fp_add_unpack.sv
src/fp_add_align.sv
src/fp_add_sum.sv
src/fp_add_normalize.sv
src/fp_adder.sv
verif/fp_adder_tb.sv
